// ==== compile.f ====
hw/nes_mem_pkg.sv
hw/load_sequencer.sv
hw/backup_engine.sv
hw/shared_ram_arbiter.sv
hw/nes_mem_top.sv
test/nes_mem_asserts.sv
test/nes_mem_tb.sv

// ==== hw/backup_engine.sv ====
// save RAM backup engine
// loads and saves save RAM over the SD sector interface
`timescale 1ns/10ps
`default_nettype none

module backup_engine import nes_mem_pkg::*; (
	input  logic       clk,
	input  logic       reset_nes,
	input  logic       img_mounted,
	input  img_size_t  img_size,
	input  logic       bk_save,
	input  logic       dl_active,
	input  logic       sd_ack,
	input  buff_addr_t sd_buff_addr,
	input  logic       sd_buff_wr,
	input  logic       sd_buff_rd,
	input  mem_data_t  sd_buff_dout,
	input  logic       backup_gnt,
	input  mem_data_t  backup_rdata,
	output sd_lba_t    sd_lba,
	output logic       sd_rd,
	output logic       sd_wr,
	output mem_data_t  sd_buff_din,
	output logic       bk_ena,
	output logic       backup_req,
	output logic       backup_we,
	output mem_addr_t  backup_addr,
	output mem_data_t  backup_wdata
);

	bk_state_t state;
	logic img_mounted_d;
	logic bk_save_d;
	logic dl_active_d;
	logic sd_ack_d;
	logic mount_rise;
	logic save_rise;
	logic dl_rise;
	logic ack_rise;
	logic ack_fall;
	logic mount_load;
	logic save_start;
	logic loading;
	sav_sector_t sector;
	sav_sector_t last_sector;
	sav_sector_t size_last;
	img_size_t img_sectors;

	assign mount_rise = img_mounted & ~img_mounted_d;
	assign save_rise = bk_save & ~bk_save_d;
	assign dl_rise = dl_active & ~dl_active_d;
	assign ack_rise = sd_ack & ~sd_ack_d;
	assign ack_fall = ~sd_ack & sd_ack_d;

	assign mount_load = mount_rise & (|img_size);
	assign save_start = save_rise & bk_ena;

	// last sector index, clamped to the save region
	assign img_sectors = img_size / SECTOR_BYTES;

	always_comb begin
		if (img_sectors >= SAV_MAX_SECTORS) begin
			size_last = sav_sector_t'(SAV_MAX_SECTORS - 1);
		end else if (img_sectors == '0) begin
			size_last = '0;
		end else begin
			size_last = sav_sector_t'(img_sectors - 1);
		end
	end

	always_ff @(posedge clk) begin
		if (mount_load) begin
			last_sector <= size_last;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			img_mounted_d <= 1'b0;
			bk_save_d <= 1'b0;
			dl_active_d <= 1'b0;
			sd_ack_d <= 1'b0;
			state <= BK_IDLE;
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
			bk_ena <= 1'b0;
			loading <= 1'b0;
			sector <= '0;
		end else begin
			img_mounted_d <= img_mounted;
			bk_save_d <= bk_save;
			dl_active_d <= dl_active;
			sd_ack_d <= sd_ack;

			if (mount_rise) begin
				bk_ena <= |img_size;
			end
			// a new ROM invalidates the mounted save
			if (dl_rise) begin
				bk_ena <= 1'b0;
			end

			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (mount_load || save_start) begin
						state <= BK_XFER;
						sector <= '0;
						loading <= mount_load;
						sd_rd <= mount_load;
						sd_wr <= ~mount_load;
					end
				end
				BK_XFER: begin
					if (ack_fall) begin
						if (sector == last_sector) begin
							state <= BK_IDLE;
							loading <= 1'b0;
						end else begin
							sector <= sector + 1'b1;
							sd_rd <= loading;
							sd_wr <= ~loading;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	// one RAM request per byte strobe
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			backup_req <= 1'b0;
		end else if (state == BK_XFER && (sd_buff_wr || sd_buff_rd)) begin
			backup_req <= 1'b1;
		end else if (backup_gnt) begin
			backup_req <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (sd_buff_wr || sd_buff_rd) begin
			backup_we <= sd_buff_wr;
			backup_addr <= SAV_BASE + mem_addr_t'({sector, sd_buff_addr});
			backup_wdata <= sd_buff_dout;
		end
	end

	assign sd_buff_din = backup_rdata;
	assign sd_lba = sd_lba_t'(sector);

endmodule

`default_nettype wire

// ==== hw/load_sequencer.sv ====
// ROM download loader
// stages download bytes as RAM writes and sequences the machine reset
`timescale 1ns/10ps
`default_nettype none

module load_sequencer import nes_mem_pkg::*; (
	input  logic      clk,
	input  logic      reset_nes,
	input  logic      dl_active,
	input  logic      dl_wr,
	input  mem_data_t dl_data,
	input  logic      loader_gnt,
	output logic      loader_req,
	output mem_addr_t loader_addr,
	output mem_data_t loader_wdata,
	output logic      machine_reset
);

	logic dl_active_d;
	logic dl_rise;
	mem_addr_t load_addr;
	mem_addr_t cur_addr;
	logic init_reset;
	logic [$bits(DOWNLOAD_RESET_CYCLES)-1:0] hold_cnt;

	assign dl_rise = dl_active & ~dl_active_d;

	// first byte of a new download goes to address 0
	assign cur_addr = dl_rise ? '0 : load_addr;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			dl_active_d <= 1'b0;
			load_addr <= '0;
			loader_req <= 1'b0;
		end else begin
			dl_active_d <= dl_active;
			if (dl_wr) begin
				load_addr <= cur_addr + mem_addr_t'(1);
				loader_req <= 1'b1;
			end else begin
				if (dl_rise) begin
					load_addr <= '0;
				end
				if (loader_gnt) begin
					loader_req <= 1'b0;
				end
			end
		end
	end

	// one-deep write stage
	always_ff @(posedge clk) begin
		if (dl_wr) begin
			loader_addr <= cur_addr;
			loader_wdata <= dl_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			init_reset <= 1'b1;
			hold_cnt <= '0;
		end else begin
			if (dl_active) begin
				init_reset <= 1'b0;
			end
			// count only once the last byte has drained
			if (dl_active) begin
				hold_cnt <= DOWNLOAD_RESET_CYCLES;
			end else if (!loader_req && hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
		end
	end

	assign machine_reset = reset_nes | init_reset | dl_active | (hold_cnt != '0);

endmodule

`default_nettype wire

// ==== hw/nes_mem_pkg.sv ====
// memory front end shared definitions
// widths, memory map and backup FSM states
`default_nettype none

package nes_mem_pkg;

	typedef logic [13:0] mem_addr_t;
	typedef logic [7:0]  mem_data_t;
	typedef logic [8:0]  buff_addr_t;
	typedef logic [31:0] sd_lba_t;
	typedef logic [31:0] img_size_t;
	typedef logic [3:0]  sav_sector_t;

	typedef enum logic {
		BK_IDLE,
		BK_XFER
	} bk_state_t;

	// cartridge image below, save RAM from here up
	localparam mem_addr_t SAV_BASE = 14'd8192;

	localparam int SECTOR_BYTES    = 512;
	localparam int SAV_MAX_SECTORS = 16;

	// machine held in reset this long once a download ends
	localparam logic [7:0] DOWNLOAD_RESET_CYCLES = 8'd255;

endpackage

`default_nettype wire

// ==== hw/nes_mem_top.sv ====
// NES memory front end top
// loader, backup engine and CPU port sharing one RAM
`timescale 1ns/10ps
`default_nettype none

module nes_mem_top import nes_mem_pkg::*; (
	input  logic       clk,
	input  logic       reset_nes,

	// ROM download
	input  logic       dl_active,
	input  logic       dl_wr,
	input  mem_data_t  dl_data,
	output logic       machine_reset,

	// image mount and save trigger
	input  logic       img_mounted,
	input  img_size_t  img_size,
	input  logic       bk_save,
	output logic       bk_ena,

	// SD sector interface
	output sd_lba_t    sd_lba,
	output logic       sd_rd,
	output logic       sd_wr,
	input  logic       sd_ack,
	input  buff_addr_t sd_buff_addr,
	input  logic       sd_buff_wr,
	input  logic       sd_buff_rd,
	input  mem_data_t  sd_buff_dout,
	output mem_data_t  sd_buff_din,

	// CPU port
	input  logic       cpu_req,
	input  logic       cpu_we,
	input  mem_addr_t  cpu_addr,
	input  mem_data_t  cpu_wdata,
	output logic       cpu_gnt,
	output mem_data_t  cpu_rdata
);

	logic loader_req;
	logic loader_gnt;
	mem_addr_t loader_addr;
	mem_data_t loader_wdata;

	logic backup_req;
	logic backup_gnt;
	logic backup_we;
	mem_addr_t backup_addr;
	mem_data_t backup_wdata;
	mem_data_t backup_rdata;

	load_sequencer load_sequencer0 (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.dl_active     (dl_active),
		.dl_wr         (dl_wr),
		.dl_data       (dl_data),
		.loader_gnt    (loader_gnt),
		.loader_req    (loader_req),
		.loader_addr   (loader_addr),
		.loader_wdata  (loader_wdata),
		.machine_reset (machine_reset)
	);

	backup_engine backup_engine0 (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.img_mounted  (img_mounted),
		.img_size     (img_size),
		.bk_save      (bk_save),
		.dl_active    (dl_active),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_wr   (sd_buff_wr),
		.sd_buff_rd   (sd_buff_rd),
		.sd_buff_dout (sd_buff_dout),
		.backup_gnt   (backup_gnt),
		.backup_rdata (backup_rdata),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_buff_din  (sd_buff_din),
		.bk_ena       (bk_ena),
		.backup_req   (backup_req),
		.backup_we    (backup_we),
		.backup_addr  (backup_addr),
		.backup_wdata (backup_wdata)
	);

	// the loader only ever writes
	shared_ram_arbiter shared_ram_arbiter0 (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.loader_req   (loader_req),
		.loader_we    (1'b1),
		.loader_addr  (loader_addr),
		.loader_wdata (loader_wdata),
		.loader_gnt   (loader_gnt),
		.backup_req   (backup_req),
		.backup_we    (backup_we),
		.backup_addr  (backup_addr),
		.backup_wdata (backup_wdata),
		.backup_gnt   (backup_gnt),
		.backup_rdata (backup_rdata),
		.cpu_req      (cpu_req),
		.cpu_we       (cpu_we),
		.cpu_addr     (cpu_addr),
		.cpu_wdata    (cpu_wdata),
		.cpu_gnt      (cpu_gnt),
		.cpu_rdata    (cpu_rdata)
	);

endmodule

`default_nettype wire

// ==== hw/shared_ram_arbiter.sv ====
// shared RAM with fixed-priority arbitration
// loader over backup over cpu, one access per cycle
`timescale 1ns/10ps
`default_nettype none

module shared_ram_arbiter import nes_mem_pkg::*; (
	input  logic      clk,
	input  logic      reset_nes,

	input  logic      loader_req,
	input  logic      loader_we,
	input  mem_addr_t loader_addr,
	input  mem_data_t loader_wdata,
	output logic      loader_gnt,

	input  logic      backup_req,
	input  logic      backup_we,
	input  mem_addr_t backup_addr,
	input  mem_data_t backup_wdata,
	output logic      backup_gnt,
	output mem_data_t backup_rdata,

	input  logic      cpu_req,
	input  logic      cpu_we,
	input  mem_addr_t cpu_addr,
	input  mem_data_t cpu_wdata,
	output logic      cpu_gnt,
	output mem_data_t cpu_rdata
);

	mem_data_t ram [2**$bits(mem_addr_t)];

	logic any_gnt;
	logic sel_we;
	mem_addr_t sel_addr;
	mem_data_t sel_wdata;

	// grants follow requests in the same cycle
	assign loader_gnt = loader_req;
	assign backup_gnt = backup_req & ~loader_req;
	assign cpu_gnt = cpu_req & ~loader_req & ~backup_req;
	assign any_gnt = loader_req | backup_req | cpu_req;

	always_comb begin
		if (loader_req) begin
			sel_we = loader_we;
			sel_addr = loader_addr;
			sel_wdata = loader_wdata;
		end else if (backup_req) begin
			sel_we = backup_we;
			sel_addr = backup_addr;
			sel_wdata = backup_wdata;
		end else begin
			sel_we = cpu_we;
			sel_addr = cpu_addr;
			sel_wdata = cpu_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (any_gnt && sel_we) begin
			ram[sel_addr] <= sel_wdata;
		end
	end

	// read data held per requester until its next read
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			backup_rdata <= '0;
			cpu_rdata <= '0;
		end else begin
			if (backup_gnt && !backup_we) begin
				backup_rdata <= ram[sel_addr];
			end
			if (cpu_gnt && !cpu_we) begin
				cpu_rdata <= ram[sel_addr];
			end
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module nes_mem_tb -f compile.f
output=$(./obj_dir/Vnes_mem_tb 2>&1) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi

// ==== test/nes_mem_asserts.sv ====
// arbiter protocol checks
// single grant, grant only with request, loader never waits
`timescale 1ns/10ps
`default_nettype none

module nes_mem_asserts (
	input logic clk,
	input logic reset_nes,
	input logic loader_req,
	input logic loader_gnt,
	input logic backup_req,
	input logic backup_gnt,
	input logic cpu_req,
	input logic cpu_gnt
);

	one_grant: assert property (@(posedge clk) disable iff (reset_nes)
		$onehot0({loader_gnt, backup_gnt, cpu_gnt}))
		else $error("more than one grant in a cycle");

	grant_has_req: assert property (@(posedge clk) disable iff (reset_nes)
		(!loader_gnt || loader_req) && (!backup_gnt || backup_req) && (!cpu_gnt || cpu_req))
		else $error("grant without a request");

	loader_at_once: assert property (@(posedge clk) disable iff (reset_nes)
		loader_req |-> loader_gnt)
		else $error("loader request not granted in its cycle");

endmodule

bind shared_ram_arbiter nes_mem_asserts nes_mem_asserts0 (
	.clk        (clk),
	.reset_nes  (reset_nes),
	.loader_req (loader_req),
	.loader_gnt (loader_gnt),
	.backup_req (backup_req),
	.backup_gnt (backup_gnt),
	.cpu_req    (cpu_req),
	.cpu_gnt    (cpu_gnt)
);

`default_nettype wire

// ==== test/nes_mem_tb.sv ====
// testbench for the NES memory front end
// random download, CPU, mount and save traffic checked against a RAM model
`timescale 1ns/10ps
`default_nettype none

module nes_mem_tb import nes_mem_pkg::*; ();

	logic clk;
	logic reset_nes;
	logic dl_active;
	logic dl_wr;
	mem_data_t dl_data;
	logic machine_reset;
	logic img_mounted;
	img_size_t img_size;
	logic bk_save;
	logic bk_ena;
	sd_lba_t sd_lba;
	logic sd_rd;
	logic sd_wr;
	logic sd_ack;
	buff_addr_t sd_buff_addr;
	logic sd_buff_wr;
	logic sd_buff_rd;
	mem_data_t sd_buff_dout;
	mem_data_t sd_buff_din;
	logic cpu_req;
	logic cpu_we;
	mem_addr_t cpu_addr;
	mem_data_t cpu_wdata;
	logic cpu_gnt;
	mem_data_t cpu_rdata;

	// reference copy of the shared RAM
	mem_data_t model [2**$bits(mem_addr_t)];
	bit known [2**$bits(mem_addr_t)];

	nes_mem_top dut0 (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.dl_active     (dl_active),
		.dl_wr         (dl_wr),
		.dl_data       (dl_data),
		.machine_reset (machine_reset),
		.img_mounted   (img_mounted),
		.img_size      (img_size),
		.bk_save       (bk_save),
		.bk_ena        (bk_ena),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.sd_ack        (sd_ack),
		.sd_buff_addr  (sd_buff_addr),
		.sd_buff_wr    (sd_buff_wr),
		.sd_buff_rd    (sd_buff_rd),
		.sd_buff_dout  (sd_buff_dout),
		.sd_buff_din   (sd_buff_din),
		.cpu_req       (cpu_req),
		.cpu_we        (cpu_we),
		.cpu_addr      (cpu_addr),
		.cpu_wdata     (cpu_wdata),
		.cpu_gnt       (cpu_gnt),
		.cpu_rdata     (cpu_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_on_error();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout waiting for %s", what);
		stop_on_error();
	endtask

	task automatic check_data(input string name, input mem_data_t exp, input mem_data_t act);
		if (exp !== act) begin
			$display("Fail %s expected %h actual %h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_lba(input string name, input sd_lba_t exp, input sd_lba_t act);
		if (exp !== act) begin
			$display("Fail %s expected %0d actual %0d", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Fail %s expected %b actual %b", name, exp, act);
			stop_on_error();
		end
	endtask

	// one CPU access, read data sampled in the cycle after the grant
	task automatic cpu_access(input logic we, input mem_addr_t addr, input mem_data_t wdata,
		output mem_data_t rdata);
		int waited;
		waited = 0;
		@(posedge clk);
		cpu_req <= 1'b1;
		cpu_we <= we;
		cpu_addr <= addr;
		cpu_wdata <= wdata;
		@(negedge clk);
		while (!cpu_gnt) begin
			waited++;
			if (waited > 100) report_timeout("the CPU grant");
			@(negedge clk);
		end
		@(posedge clk);
		cpu_req <= 1'b0;
		cpu_we <= 1'b0;
		@(negedge clk);
		rdata = cpu_rdata;
	endtask

	task automatic download(input int nbytes);
		mem_data_t b;
		int held;
		@(posedge clk);
		dl_active <= 1'b1;
		for (int i = 0; i < nbytes; i++) begin
			b = mem_data_t'($urandom);
			@(posedge clk);
			dl_wr <= 1'b1;
			dl_data <= b;
			model[mem_addr_t'(i)] = b;
			known[mem_addr_t'(i)] = 1'b1;
			@(posedge clk);
			dl_wr <= 1'b0;
			repeat ($urandom_range(3, 0)) @(posedge clk);
		end
		@(negedge clk);
		check_bit("reset_during_download", 1'b1, machine_reset);
		repeat (2) @(posedge clk);
		dl_active <= 1'b0;
		// count the cycles machine_reset stays up after the download
		held = 0;
		@(negedge clk);
		while (machine_reset) begin
			held++;
			if (held > 1000) report_timeout("machine_reset to fall after the download");
			@(negedge clk);
		end
		check_bit("reset_hold_min", 1'b1, held >= 255);
	endtask

	task automatic mount_image(input img_size_t size);
		@(posedge clk);
		img_size <= size;
		img_mounted <= 1'b1;
		@(posedge clk);
		img_mounted <= 1'b0;
	endtask

	task automatic pulse_save();
		@(posedge clk);
		bk_save <= 1'b1;
		@(posedge clk);
		bk_save <= 1'b0;
	endtask

	task automatic wait_sd_request(input logic want_rd);
		int waited;
		waited = 0;
		@(negedge clk);
		while ((want_rd ? sd_rd : sd_wr) == 1'b0) begin
			waited++;
			if (waited > 200) report_timeout("an SD sector request");
			@(negedge clk);
		end
		check_bit("sd_other_request", 1'b0, want_rd ? sd_wr : sd_rd);
	endtask

	// SD card side of a load, random sector contents
	task automatic serve_load(input int sectors);
		mem_data_t b;
		mem_addr_t a;
		for (int s = 0; s < sectors; s++) begin
			wait_sd_request(1'b1);
			check_lba("load_lba", sd_lba_t'(s), sd_lba);
			@(posedge clk);
			sd_ack <= 1'b1;
			for (int off = 0; off < SECTOR_BYTES; off++) begin
				b = mem_data_t'($urandom);
				a = SAV_BASE + mem_addr_t'(s * SECTOR_BYTES + off);
				model[a] = b;
				@(posedge clk);
				sd_buff_addr <= buff_addr_t'(off);
				sd_buff_dout <= b;
				sd_buff_wr <= 1'b1;
				@(posedge clk);
				sd_buff_wr <= 1'b0;
				repeat (2) @(posedge clk);
			end
			@(posedge clk);
			sd_ack <= 1'b0;
		end
	endtask

	// SD card side of a save, every byte checked on the third edge
	task automatic serve_save(input int sectors);
		mem_addr_t a;
		for (int s = 0; s < sectors; s++) begin
			wait_sd_request(1'b0);
			check_lba("save_lba", sd_lba_t'(s), sd_lba);
			@(posedge clk);
			sd_ack <= 1'b1;
			for (int off = 0; off < SECTOR_BYTES; off++) begin
				a = SAV_BASE + mem_addr_t'(s * SECTOR_BYTES + off);
				@(posedge clk);
				sd_buff_addr <= buff_addr_t'(off);
				sd_buff_rd <= 1'b1;
				@(posedge clk);
				sd_buff_rd <= 1'b0;
				repeat (2) @(posedge clk);
				@(negedge clk);
				check_data("save_byte", model[a], sd_buff_din);
			end
			@(posedge clk);
			sd_ack <= 1'b0;
		end
	endtask

	task automatic expect_idle_sd(input string name, input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_bit({name, "_sd_rd"}, 1'b0, sd_rd);
			check_bit({name, "_sd_wr"}, 1'b0, sd_wr);
		end
	endtask

	initial begin
		int rom_bytes;
		int sectors;
		mem_addr_t addr;
		mem_data_t wdata;
		mem_data_t rdata;

		void'($urandom(30));
		reset_nes <= 1'b1;
		dl_active <= 1'b0;
		dl_wr <= 1'b0;
		dl_data <= '0;
		img_mounted <= 1'b0;
		img_size <= '0;
		bk_save <= 1'b0;
		sd_ack <= 1'b0;
		sd_buff_addr <= '0;
		sd_buff_wr <= 1'b0;
		sd_buff_rd <= 1'b0;
		sd_buff_dout <= '0;
		cpu_req <= 1'b0;
		cpu_we <= 1'b0;
		cpu_addr <= '0;
		cpu_wdata <= '0;
		repeat (4) @(posedge clk);
		reset_nes <= 1'b0;

		@(negedge clk);
		check_bit("reset_bk_ena", 1'b0, bk_ena);
		check_bit("reset_sd_rd", 1'b0, sd_rd);
		check_bit("reset_sd_wr", 1'b0, sd_wr);
		repeat (20) begin
			check_bit("reset_before_download", 1'b1, machine_reset);
			@(negedge clk);
		end

		rom_bytes = 280 + $urandom_range(40, 0);
		download(rom_bytes);
		for (int i = 0; i < rom_bytes; i++) begin
			cpu_access(1'b0, mem_addr_t'(i), '0, rdata);
			check_data("download_read", model[mem_addr_t'(i)], rdata);
		end

		// reads only where the model holds a value
		for (int i = 0; i < 300; i++) begin
			addr = mem_addr_t'($urandom_range(SAV_BASE - 1, 0));
			if ($urandom_range(1, 0) == 1 || !known[addr]) begin
				wdata = mem_data_t'($urandom);
				cpu_access(1'b1, addr, wdata, rdata);
				model[addr] = wdata;
				known[addr] = 1'b1;
			end else begin
				cpu_access(1'b0, addr, '0, rdata);
				check_data("cpu_rom_read", model[addr], rdata);
			end
		end

		sectors = $urandom_range(SAV_MAX_SECTORS, 1);
		mount_image(img_size_t'(sectors * SECTOR_BYTES));
		serve_load(sectors);
		@(negedge clk);
		check_bit("bk_ena_after_mount", 1'b1, bk_ena);
		for (int i = 0; i < sectors * SECTOR_BYTES; i++) begin
			addr = SAV_BASE + mem_addr_t'(i);
			cpu_access(1'b0, addr, '0, rdata);
			check_data("save_region_read", model[addr], rdata);
		end

		for (int i = 0; i < 200; i++) begin
			addr = SAV_BASE + mem_addr_t'($urandom_range(sectors * SECTOR_BYTES - 1, 0));
			wdata = mem_data_t'($urandom);
			cpu_access(1'b1, addr, wdata, rdata);
			model[addr] = wdata;
		end
		pulse_save();
		serve_save(sectors);

		// a new ROM drops the save enable
		download(20);
		check_bit("bk_ena_after_download", 1'b0, bk_ena);
		pulse_save();
		expect_idle_sd("save_without_ena", 50);
		mount_image('0);
		expect_idle_sd("empty_mount", 50);
		check_bit("bk_ena_empty_mount", 1'b0, bk_ena);

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire
